/* verilog.f */
+incdir+.
cpu_pkg.sv
cpu_gpr.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_memwb.sv
cpu_top.sv
tb_cpu.sv

/* Bender.yml */
package:
  name: rv32i_mc_cpu

sources:
  - files:
      - cpu_pkg.sv
      - cpu_gpr.sv
      - cpu_fetch.sv
      - cpu_decode.sv
      - cpu_execute.sv
      - cpu_memwb.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv

/* tb_cpu_model.svh */
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

localparam int          PROG_LEN    = 120;
localparam int          RAM_WORDS   = 64;
localparam int          NUM_KINDS   = 13;
localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

// Instruction kinds, in the order the generator draws them
localparam int K_ADDI = 0;
localparam int K_ADD  = 1;
localparam int K_SUB  = 2;
localparam int K_AND  = 3;
localparam int K_OR   = 4;
localparam int K_XOR  = 5;
localparam int K_SLT  = 6;
localparam int K_LUI  = 7;
localparam int K_LW   = 8;
localparam int K_SW   = 9;
localparam int K_BEQ  = 10;
localparam int K_BNE  = 11;
localparam int K_JAL  = 12;

// Fields of each generated instruction
int unsigned f_kind [PROG_LEN];
logic [4:0]  f_rd   [PROG_LEN];
logic [4:0]  f_rs1  [PROG_LEN];
logic [4:0]  f_rs2  [PROG_LEN];
logic [31:0] f_imm  [PROG_LEN];

logic [31:0] model_ram [0:RAM_WORDS-1];
logic [31:0] exp_pc [$];
logic [31:0] exp_ld [$];
logic [31:0] exp_st_addr [$];
logic [31:0] exp_st_data [$];
logic [31:0] exp_x10;

// Steps the program one instruction at a time until EBREAK is reached
task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] pc;
    logic [31:0] next_pc;
    int          idx;
    bit          wr;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    pc  = '0;
    idx = 0;
    exp_pc.push_back(pc);
    while (idx != PROG_LEN) begin
        a       = regs[f_rs1[idx]];
        b       = regs[f_rs2[idx]];
        res     = '0;
        wr      = 1'b1;
        next_pc = pc + 32'd4;
        case (f_kind[idx])
            K_ADDI: res = a + f_imm[idx];
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_LUI:  res = f_imm[idx];
            K_LW: begin
                exp_ld.push_back(a + f_imm[idx]);
                res = model_ram[(a + f_imm[idx]) >> 2];
            end
            K_SW: begin
                wr = 1'b0;
                exp_st_addr.push_back(a + f_imm[idx]);
                exp_st_data.push_back(b);
                model_ram[(a + f_imm[idx]) >> 2] = b;
            end
            K_BEQ: begin
                wr = 1'b0;
                if (a == b) begin
                    next_pc = pc + f_imm[idx];
                end
            end
            K_BNE: begin
                wr = 1'b0;
                if (a != b) begin
                    next_pc = pc + f_imm[idx];
                end
            end
            default: begin
                res     = pc + 32'd4;
                next_pc = pc + f_imm[idx];
            end
        endcase
        if (wr && f_rd[idx] != 5'd0) begin
            regs[f_rd[idx]] = res;
        end
        pc  = next_pc;
        idx = pc >> 2;
        exp_pc.push_back(pc);
    end
    exp_x10 = regs[10];
endtask

`endif

/* tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

    `include "tb_cpu_model.svh"

    localparam int TIMEOUT_CYCLES = 5 * (PROG_LEN + 1) + 50;

    logic        sys_clk = 1'b0;
    logic        arst_n;
    logic        rom_rd_en;
    logic [31:0] rom_rd_addr;
    logic [31:0] rom_rd_data;
    logic        ram_rd_en;
    logic [31:0] ram_rd_addr;
    logic [31:0] ram_rd_data;
    logic        ram_wr_en;
    logic [31:0] ram_wr_addr;
    logic [31:0] ram_wr_data;
    logic        end_flag;
    logic [31:0] end_data;

    logic [31:0] rom [0:PROG_LEN];
    logic [31:0] ram [0:RAM_WORDS-1];
    integer      seed;
    int          errors;
    int          run_cycles;

    cpu_top dut_i (
        .i_sys_clk    (sys_clk),
        .i_arst_n     (arst_n),
        .i_rom_rd_data(rom_rd_data),
        .o_rom_rd_en  (rom_rd_en),
        .o_rom_rd_addr(rom_rd_addr),
        .i_ram_rd_data(ram_rd_data),
        .o_ram_rd_en  (ram_rd_en),
        .o_ram_rd_addr(ram_rd_addr),
        .o_ram_wr_en  (ram_wr_en),
        .o_ram_wr_addr(ram_wr_addr),
        .o_ram_wr_data(ram_wr_data),
        .o_end_flag   (end_flag),
        .o_end_data   (end_data)
    );

    // Both memories answer in the same cycle
    assign rom_rd_data = rom[rom_rd_addr[31:2]];
    assign ram_rd_data = ram[ram_rd_addr[7:2]];

    always #4 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        if (ram_wr_en) begin
            ram[ram_wr_addr[7:2]] <= ram_wr_data;
        end
        if (arst_n) begin
            run_cycles <= run_cycles + 1;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    function automatic logic [31:0] encode_inst(input int i);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        rd  = f_rd[i];
        rs1 = f_rs1[i];
        rs2 = f_rs2[i];
        imm = f_imm[i];
        case (f_kind[i])
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_LUI:  return {imm[31:12], rd, 7'b0110111};
            K_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default: return EBREAK_WORD;
        endcase
    endfunction

    task automatic gen_program();
        logic [31:0] r;
        int unsigned kind;
        for (int i = 0; i < PROG_LEN; i++) begin
            r    = $random(seed);
            kind = r[7:0] % NUM_KINDS;
            // Jumps go forward and must land on or before the final EBREAK
            if (kind >= K_BEQ && i + 3 > PROG_LEN) begin
                kind = K_ADDI;
            end
            f_kind[i] = kind;
            f_rd[i]   = r[11:8] % 12;
            f_rs1[i]  = r[15:12] % 12;
            f_rs2[i]  = r[19:16] % 12;
            r         = $random(seed);
            case (kind)
                K_ADDI:              f_imm[i] = {{20{r[11]}}, r[11:0]};
                K_LUI:               f_imm[i] = {r[19:0], 12'b0};
                K_LW, K_SW:          f_imm[i] = {24'b0, r[5:0], 2'b00};
                K_BEQ, K_BNE, K_JAL: f_imm[i] = r[0] ? 32'd12 : 32'd8;
                default:             f_imm[i] = '0;
            endcase
            if (kind == K_LW || kind == K_SW) begin
                f_rs1[i] = 5'd0;
            end
            if (kind == K_JAL && f_rd[i] == 5'd0) begin
                f_rd[i] = 5'd1;
            end
            rom[i] = encode_inst(i);
        end
        rom[PROG_LEN] = EBREAK_WORD;
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge sys_clk) begin
        if (run_cycles <= 1) begin
            check_value("end flag around reset", end_flag, 1'b0);
            check_value("RAM read enable around reset", ram_rd_en, 1'b0);
            check_value("RAM write enable around reset", ram_wr_en, 1'b0);
        end
        if (rom_rd_en) begin
            if (exp_pc.size() == 0) begin
                report_failure($sformatf("Fetch at %h after the program had ended", rom_rd_addr));
            end else begin
                check_value("fetch address", rom_rd_addr, exp_pc.pop_front());
            end
        end
        if (ram_rd_en) begin
            if (exp_ld.size() == 0) begin
                report_failure($sformatf("Load from %h that the program never makes", ram_rd_addr));
            end else begin
                check_value("load address", ram_rd_addr, exp_ld.pop_front());
            end
        end
        if (ram_wr_en) begin
            if (exp_st_addr.size() == 0) begin
                report_failure($sformatf("Store to %h that the program never makes", ram_wr_addr));
            end else begin
                check_value("store address", ram_wr_addr, exp_st_addr.pop_front());
                check_value("store data", ram_wr_data, exp_st_data.pop_front());
            end
        end
    end

    initial begin
        wait (run_cycles == TIMEOUT_CYCLES);
        errors++;
        $display("Timeout: the end flag never rose within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d", errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        seed       = 60;
        errors     = 0;
        run_cycles = 0;
        gen_program();
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i]       = $random(seed);
            model_ram[i] = ram[i];
        end
        run_model();

        repeat (3) @(posedge sys_clk);
        arst_n <= 1'b1;

        wait (end_flag === 1'b1);
        @(negedge sys_clk);
        check_value("end data (x10)", end_data, exp_x10);
        // The core must stay halted
        repeat (10) @(negedge sys_clk);

        if (exp_pc.size() != 0) begin
            report_failure($sformatf("%0d expected fetches never happened", exp_pc.size()));
        end
        if (exp_ld.size() != 0) begin
            report_failure($sformatf("%0d expected loads never happened", exp_ld.size()));
        end
        if (exp_st_addr.size() != 0) begin
            report_failure($sformatf("%0d expected stores never happened", exp_st_addr.size()));
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* cpu_top.sv */
`timescale 1ns/10ps

module cpu_top (
    input  logic           i_sys_clk,
    input  logic           i_arst_n,
    input  cpu_pkg::inst_t i_rom_rd_data,
    output logic           o_rom_rd_en,
    output cpu_pkg::addr_t o_rom_rd_addr,
    input  cpu_pkg::word_t i_ram_rd_data,
    output logic           o_ram_rd_en,
    output cpu_pkg::addr_t o_ram_rd_addr,
    output logic           o_ram_wr_en,
    output cpu_pkg::addr_t o_ram_wr_addr,
    output cpu_pkg::word_t o_ram_wr_data,
    output logic           o_end_flag,
    output cpu_pkg::word_t o_end_data
);

    import cpu_pkg::*;

    // Register file read data
    word_t    w_rs1_data;
    word_t    w_rs2_data;

    // Decode to execute
    reg_idx_t w_dec_rs1_idx;
    reg_idx_t w_dec_rs2_idx;
    logic     w_dec_valid;
    alu_op_e  w_dec_alu_op;
    word_t    w_dec_opa;
    word_t    w_dec_opb;
    word_t    w_dec_store_data;
    logic     w_dec_is_load;
    logic     w_dec_is_store;
    logic     w_dec_is_beq;
    logic     w_dec_is_bne;
    logic     w_dec_is_jal;
    word_t    w_dec_imm;
    addr_t    w_dec_pc;
    reg_idx_t w_dec_rd_idx;
    logic     w_dec_rd_wr_en;
    wb_src_e  w_dec_wb_src;

    // Execute to memwb
    logic     w_exe_valid;
    word_t    w_exe_result;
    word_t    w_exe_store_data;
    logic     w_exe_is_load;
    logic     w_exe_is_store;
    reg_idx_t w_exe_rd_idx;
    logic     w_exe_rd_wr_en;
    wb_src_e  w_exe_wb_src;
    addr_t    w_exe_next_pc;

    // Write-back and retire
    logic     w_wb_gpr_wr_en;
    reg_idx_t w_wb_gpr_wr_idx;
    word_t    w_wb_gpr_wr_data;
    logic     w_wb_retire;
    addr_t    w_wb_next_pc;

    cpu_fetch u_fetch (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_retire     (w_wb_retire),
        .i_next_pc    (w_wb_next_pc),
        .o_fetch_valid(o_rom_rd_en),
        .o_pc         (o_rom_rd_addr)
    );

    cpu_decode u_decode (
        .i_sys_clk     (i_sys_clk),
        .i_arst_n      (i_arst_n),
        .i_fetch_valid (o_rom_rd_en),
        .i_inst        (i_rom_rd_data),
        .i_pc          (o_rom_rd_addr),
        .i_rs1_data    (w_rs1_data),
        .i_rs2_data    (w_rs2_data),
        .o_rs1_idx     (w_dec_rs1_idx),
        .o_rs2_idx     (w_dec_rs2_idx),
        .o_dec_valid   (w_dec_valid),
        .o_alu_op      (w_dec_alu_op),
        .o_opa         (w_dec_opa),
        .o_opb         (w_dec_opb),
        .o_store_data  (w_dec_store_data),
        .o_is_load     (w_dec_is_load),
        .o_is_store    (w_dec_is_store),
        .o_is_branch_eq(w_dec_is_beq),
        .o_is_branch_ne(w_dec_is_bne),
        .o_is_jal      (w_dec_is_jal),
        .o_imm         (w_dec_imm),
        .o_pc          (w_dec_pc),
        .o_rd_idx      (w_dec_rd_idx),
        .o_rd_wr_en    (w_dec_rd_wr_en),
        .o_wb_src      (w_dec_wb_src),
        .o_end_flag    (o_end_flag)
    );

    cpu_execute u_execute (
        .i_sys_clk     (i_sys_clk),
        .i_arst_n      (i_arst_n),
        .i_dec_valid   (w_dec_valid),
        .i_alu_op      (w_dec_alu_op),
        .i_opa         (w_dec_opa),
        .i_opb         (w_dec_opb),
        .i_store_data  (w_dec_store_data),
        .i_is_load     (w_dec_is_load),
        .i_is_store    (w_dec_is_store),
        .i_is_branch_eq(w_dec_is_beq),
        .i_is_branch_ne(w_dec_is_bne),
        .i_is_jal      (w_dec_is_jal),
        .i_imm         (w_dec_imm),
        .i_pc          (w_dec_pc),
        .i_rd_idx      (w_dec_rd_idx),
        .i_rd_wr_en    (w_dec_rd_wr_en),
        .i_wb_src      (w_dec_wb_src),
        .o_exe_valid   (w_exe_valid),
        .o_result      (w_exe_result),
        .o_store_data  (w_exe_store_data),
        .o_is_load     (w_exe_is_load),
        .o_is_store    (w_exe_is_store),
        .o_rd_idx      (w_exe_rd_idx),
        .o_rd_wr_en    (w_exe_rd_wr_en),
        .o_wb_src      (w_exe_wb_src),
        .o_next_pc     (w_exe_next_pc)
    );

    cpu_memwb u_memwb (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_exe_valid  (w_exe_valid),
        .i_result     (w_exe_result),
        .i_store_data (w_exe_store_data),
        .i_is_load    (w_exe_is_load),
        .i_is_store   (w_exe_is_store),
        .i_rd_idx     (w_exe_rd_idx),
        .i_rd_wr_en   (w_exe_rd_wr_en),
        .i_wb_src     (w_exe_wb_src),
        .i_next_pc    (w_exe_next_pc),
        .i_ram_rd_data(i_ram_rd_data),
        .o_ram_rd_en  (o_ram_rd_en),
        .o_ram_rd_addr(o_ram_rd_addr),
        .o_ram_wr_en  (o_ram_wr_en),
        .o_ram_wr_addr(o_ram_wr_addr),
        .o_ram_wr_data(o_ram_wr_data),
        .o_gpr_wr_en  (w_wb_gpr_wr_en),
        .o_gpr_wr_idx (w_wb_gpr_wr_idx),
        .o_gpr_wr_data(w_wb_gpr_wr_data),
        .o_retire     (w_wb_retire),
        .o_next_pc    (w_wb_next_pc)
    );

    cpu_gpr u_gpr (
        .i_sys_clk (i_sys_clk),
        .i_arst_n  (i_arst_n),
        .i_rs1_idx (w_dec_rs1_idx),
        .i_rs2_idx (w_dec_rs2_idx),
        .i_wr_en   (w_wb_gpr_wr_en),
        .i_wr_idx  (w_wb_gpr_wr_idx),
        .i_wr_data (w_wb_gpr_wr_data),
        .o_rs1_data(w_rs1_data),
        .o_rs2_data(w_rs2_data),
        .o_end_data(o_end_data)
    );

endmodule

/* cpu_memwb.sv */
`timescale 1ns/10ps

module cpu_memwb (
    input  logic              i_sys_clk,
    input  logic              i_arst_n,
    input  logic              i_exe_valid,
    input  cpu_pkg::word_t    i_result,
    input  cpu_pkg::word_t    i_store_data,
    input  logic              i_is_load,
    input  logic              i_is_store,
    input  cpu_pkg::reg_idx_t i_rd_idx,
    input  logic              i_rd_wr_en,
    input  cpu_pkg::wb_src_e  i_wb_src,
    input  cpu_pkg::addr_t    i_next_pc,
    input  cpu_pkg::word_t    i_ram_rd_data,
    output logic              o_ram_rd_en,
    output cpu_pkg::addr_t    o_ram_rd_addr,
    output logic              o_ram_wr_en,
    output cpu_pkg::addr_t    o_ram_wr_addr,
    output cpu_pkg::word_t    o_ram_wr_data,
    output logic              o_gpr_wr_en,
    output cpu_pkg::reg_idx_t o_gpr_wr_idx,
    output cpu_pkg::word_t    o_gpr_wr_data,
    output logic              o_retire,
    output cpu_pkg::addr_t    o_next_pc
);

    import cpu_pkg::*;

    logic     r_valid;
    word_t    r_result;
    word_t    r_store_data;
    logic     r_is_load;
    logic     r_is_store;
    reg_idx_t r_rd_idx;
    logic     r_rd_wr_en;
    wb_src_e  r_wb_src;
    addr_t    r_next_pc;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= i_exe_valid;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_exe_valid) begin
            r_result     <= i_result;
            r_store_data <= i_store_data;
            r_is_load    <= i_is_load;
            r_is_store   <= i_is_store;
            r_rd_idx     <= i_rd_idx;
            r_rd_wr_en   <= i_rd_wr_en;
            r_wb_src     <= i_wb_src;
            r_next_pc    <= i_next_pc;
        end
    end

    // RAM answers in the same cycle
    assign o_ram_rd_en   = r_valid & r_is_load;
    assign o_ram_rd_addr = r_result;
    assign o_ram_wr_en   = r_valid & r_is_store;
    assign o_ram_wr_addr = r_result;
    assign o_ram_wr_data = r_store_data;

    assign o_gpr_wr_en   = r_valid & r_rd_wr_en & (r_rd_idx != '0);
    assign o_gpr_wr_idx  = r_rd_idx;
    assign o_gpr_wr_data = (r_wb_src == WB_LOAD) ? i_ram_rd_data : r_result;

    assign o_retire  = r_valid;
    assign o_next_pc = r_next_pc;

endmodule

/* cpu_execute.sv */
`timescale 1ns/10ps

module cpu_execute (
    input  logic              i_sys_clk,
    input  logic              i_arst_n,
    input  logic              i_dec_valid,
    input  cpu_pkg::alu_op_e  i_alu_op,
    input  cpu_pkg::word_t    i_opa,
    input  cpu_pkg::word_t    i_opb,
    input  cpu_pkg::word_t    i_store_data,
    input  logic              i_is_load,
    input  logic              i_is_store,
    input  logic              i_is_branch_eq,
    input  logic              i_is_branch_ne,
    input  logic              i_is_jal,
    input  cpu_pkg::word_t    i_imm,
    input  cpu_pkg::addr_t    i_pc,
    input  cpu_pkg::reg_idx_t i_rd_idx,
    input  logic              i_rd_wr_en,
    input  cpu_pkg::wb_src_e  i_wb_src,
    output logic              o_exe_valid,
    output cpu_pkg::word_t    o_result,
    output cpu_pkg::word_t    o_store_data,
    output logic              o_is_load,
    output logic              o_is_store,
    output cpu_pkg::reg_idx_t o_rd_idx,
    output logic              o_rd_wr_en,
    output cpu_pkg::wb_src_e  o_wb_src,
    output cpu_pkg::addr_t    o_next_pc
);

    import cpu_pkg::*;

    word_t w_alu_res;
    word_t w_result;
    addr_t w_pc_plus4;
    logic  w_equal;
    logic  w_take;

    always_comb begin
        case (i_alu_op)
            ALU_SUB:    w_alu_res = i_opa - i_opb;
            ALU_AND:    w_alu_res = i_opa & i_opb;
            ALU_OR:     w_alu_res = i_opa | i_opb;
            ALU_XOR:    w_alu_res = i_opa ^ i_opb;
            ALU_SLT:    w_alu_res = {{(XLEN-1){1'b0}}, $signed(i_opa) < $signed(i_opb)};
            ALU_PASS_B: w_alu_res = i_opb;
            default:    w_alu_res = i_opa + i_opb;
        endcase
    end

    assign w_pc_plus4 = i_pc + PC_STEP;
    assign w_equal    = (i_opa == i_opb);
    assign w_take     = i_is_jal | (i_is_branch_eq & w_equal) | (i_is_branch_ne & ~w_equal);

    // Link address travels on the result path
    assign w_result = (i_wb_src == WB_PC4) ? w_pc_plus4 : w_alu_res;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_exe_valid <= 1'b0;
        end else begin
            o_exe_valid <= i_dec_valid;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_dec_valid) begin
            o_result     <= w_result;
            o_store_data <= i_store_data;
            o_is_load    <= i_is_load;
            o_is_store   <= i_is_store;
            o_rd_idx     <= i_rd_idx;
            o_rd_wr_en   <= i_rd_wr_en;
            o_wb_src     <= i_wb_src;
            o_next_pc    <= w_take ? (i_pc + i_imm) : w_pc_plus4;
        end
    end

endmodule

/* cpu_decode.sv */
`timescale 1ns/10ps

module cpu_decode (
    input  logic              i_sys_clk,
    input  logic              i_arst_n,
    input  logic              i_fetch_valid,
    input  cpu_pkg::inst_t    i_inst,
    input  cpu_pkg::addr_t    i_pc,
    input  cpu_pkg::word_t    i_rs1_data,
    input  cpu_pkg::word_t    i_rs2_data,
    output cpu_pkg::reg_idx_t o_rs1_idx,
    output cpu_pkg::reg_idx_t o_rs2_idx,
    output logic              o_dec_valid,
    output cpu_pkg::alu_op_e  o_alu_op,
    output cpu_pkg::word_t    o_opa,
    output cpu_pkg::word_t    o_opb,
    output cpu_pkg::word_t    o_store_data,
    output logic              o_is_load,
    output logic              o_is_store,
    output logic              o_is_branch_eq,
    output logic              o_is_branch_ne,
    output logic              o_is_jal,
    output cpu_pkg::word_t    o_imm,
    output cpu_pkg::addr_t    o_pc,
    output cpu_pkg::reg_idx_t o_rd_idx,
    output logic              o_rd_wr_en,
    output cpu_pkg::wb_src_e  o_wb_src,
    output logic              o_end_flag
);

    import cpu_pkg::*;

    inst_t      r_inst;
    addr_t      r_pc;
    logic       r_valid;
    logic       r_end;
    logic       w_is_ebreak;
    logic [6:0] w_opcode;
    logic [2:0] w_funct3;
    logic       w_use_imm;
    alu_op_e    w_alu_f3;
    word_t      w_imm_i;
    word_t      w_imm_s;
    word_t      w_imm_b;
    word_t      w_imm_u;
    word_t      w_imm_j;

    // EBREAK is the only SYSTEM instruction kept
    assign w_is_ebreak = (i_inst[6:0] == OPC_SYSTEM);

    // EBREAK never reaches execute, so it never retires
    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_valid <= 1'b0;
            r_end   <= 1'b0;
        end else begin
            r_valid <= i_fetch_valid & ~w_is_ebreak;
            if (i_fetch_valid && w_is_ebreak) begin
                r_end <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_fetch_valid) begin
            r_inst <= i_inst;
            r_pc   <= i_pc;
        end
    end

    assign w_opcode = r_inst[6:0];
    assign w_funct3 = r_inst[14:12];

    assign w_imm_i = {{20{r_inst[31]}}, r_inst[31:20]};
    assign w_imm_s = {{20{r_inst[31]}}, r_inst[31:25], r_inst[11:7]};
    assign w_imm_b = {{19{r_inst[31]}}, r_inst[31], r_inst[7], r_inst[30:25],
                      r_inst[11:8], 1'b0};
    assign w_imm_u = {r_inst[31:12], 12'b0};
    assign w_imm_j = {{11{r_inst[31]}}, r_inst[31], r_inst[19:12], r_inst[20],
                      r_inst[30:21], 1'b0};

    always_comb begin
        case (w_funct3)
            F3_SLT:  w_alu_f3 = ALU_SLT;
            F3_XOR:  w_alu_f3 = ALU_XOR;
            F3_OR:   w_alu_f3 = ALU_OR;
            F3_AND:  w_alu_f3 = ALU_AND;
            default: w_alu_f3 = ALU_ADD;
        endcase
    end

    always_comb begin
        o_alu_op       = ALU_ADD;
        o_imm          = w_imm_i;
        w_use_imm      = 1'b1;
        o_is_load      = 1'b0;
        o_is_store     = 1'b0;
        o_is_branch_eq = 1'b0;
        o_is_branch_ne = 1'b0;
        o_is_jal       = 1'b0;
        o_rd_wr_en     = 1'b0;
        o_wb_src       = WB_ALU;
        case (w_opcode)
            OPC_OP: begin
                w_use_imm  = 1'b0;
                o_alu_op   = w_alu_f3;
                o_rd_wr_en = 1'b1;
                if ((w_funct3 == F3_ADD_SUB) && r_inst[30]) begin
                    o_alu_op = ALU_SUB;
                end
            end
            OPC_OP_IMM: begin
                o_alu_op   = w_alu_f3;
                o_rd_wr_en = 1'b1;
            end
            OPC_LUI: begin
                o_alu_op   = ALU_PASS_B;
                o_imm      = w_imm_u;
                o_rd_wr_en = 1'b1;
            end
            OPC_LOAD: begin
                o_is_load  = 1'b1;
                o_rd_wr_en = 1'b1;
                o_wb_src   = WB_LOAD;
            end
            OPC_STORE: begin
                o_is_store = 1'b1;
                o_imm      = w_imm_s;
            end
            OPC_BRANCH: begin
                // Compare rs1 with rs2, offset rides on o_imm
                w_use_imm      = 1'b0;
                o_imm          = w_imm_b;
                o_is_branch_eq = (w_funct3 == F3_BEQ);
                o_is_branch_ne = (w_funct3 == F3_BNE);
            end
            OPC_JAL: begin
                o_is_jal   = 1'b1;
                o_imm      = w_imm_j;
                o_rd_wr_en = 1'b1;
                o_wb_src   = WB_PC4;
            end
            default: begin
                o_rd_wr_en = 1'b0;
            end
        endcase
    end

    assign o_rs1_idx    = r_inst[19:15];
    assign o_rs2_idx    = r_inst[24:20];
    assign o_rd_idx     = r_inst[11:7];
    assign o_opa        = i_rs1_data;
    assign o_opb        = w_use_imm ? o_imm : i_rs2_data;
    assign o_store_data = i_rs2_data;
    assign o_pc         = r_pc;
    assign o_dec_valid  = r_valid;
    assign o_end_flag   = r_end;

endmodule

/* cpu_fetch.sv */
`timescale 1ns/10ps

module cpu_fetch (
    input  logic           i_sys_clk,
    input  logic           i_arst_n,
    input  logic           i_retire,
    input  cpu_pkg::addr_t i_next_pc,
    output logic           o_fetch_valid,
    output cpu_pkg::addr_t o_pc
);

    import cpu_pkg::*;

    // One-shot kick for the first fetch after reset
    logic r_start;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_start       <= 1'b1;
            o_fetch_valid <= 1'b0;
            o_pc          <= RESET_PC;
        end else begin
            r_start       <= 1'b0;
            o_fetch_valid <= r_start | i_retire;
            if (i_retire) begin
                o_pc <= i_next_pc;
            end
        end
    end

endmodule

/* cpu_gpr.sv */
`timescale 1ns/10ps

module cpu_gpr (
    input  logic              i_sys_clk,
    input  logic              i_arst_n,
    input  cpu_pkg::reg_idx_t i_rs1_idx,
    input  cpu_pkg::reg_idx_t i_rs2_idx,
    input  logic              i_wr_en,
    input  cpu_pkg::reg_idx_t i_wr_idx,
    input  cpu_pkg::word_t    i_wr_data,
    output cpu_pkg::word_t    o_rs1_data,
    output cpu_pkg::word_t    o_rs2_data,
    output cpu_pkg::word_t    o_end_data
);

    import cpu_pkg::*;

    word_t r_regs [GPR_NUM];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_idx != '0)) begin
            r_regs[i_wr_idx] <= i_wr_data;
        end
    end

    assign o_rs1_data = r_regs[i_rs1_idx];
    assign o_rs2_data = r_regs[i_rs2_idx];
    assign o_end_data = r_regs[END_REG];

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN     = 32;
    localparam int GPR_NUM  = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // PC4 is the JAL link value
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2
    } wb_src_e;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 codes for ALU ops and branches
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam addr_t    RESET_PC = '0;
    localparam addr_t    PC_STEP  = 32'd4;
    localparam reg_idx_t END_REG  = 5'd10;

endpackage
